// ==== rtl/global_regs_pkg.sv ====
/*
 * global register block definitions
 * control-port bus types, register map, field layouts and version numbers
 */
package global_regs_pkg;

  // ----------------------------------------
  // control port bus
  // ----------------------------------------

  typedef enum logic [1:0] {
    sts_okay   = 2'd0,
    sts_cmderr = 2'd1
  } ctrl_status_e;

  // one request strobe, write wins over read
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [19:0] addr;
    logic [31:0] data;
  } ctrlport_req_t;

  typedef struct packed {
    logic         ack;
    ctrl_status_e status;
    logic [31:0]  data;
  } ctrlport_resp_t;

  // ----------------------------------------
  // register fields
  // ----------------------------------------

  typedef enum logic [1:0] {
    pps_int_25mhz = 2'd0,
    pps_int_10mhz = 2'd1,
    pps_ext       = 2'd2
  } pps_select_e;

  typedef enum logic [1:0] {
    trig_io_input      = 2'd0,
    trig_io_pps_output = 2'd1
  } trig_io_select_e;

  typedef struct packed {
    pps_select_e     pps_select;
    trig_io_select_e trig_io_select;
    logic [7:0]      pll_sync_delay;
    // write only, no self clear
    logic            pll_sync_trigger;
    logic [7:0]      pps_brc_delay;
  } clock_ctrl_t;

  typedef struct packed {
    logic [25:0] pps_prc_delay;
    logic [1:0]  prc_rc_divider;
    logic        pps_rc_enabled;
  } pps_ctrl_t;

  typedef struct packed {
    logic en_fabric_clk;
    logic en_gty_rcv_clk;
  } mfg_test_ctrl_t;

  // clocks between aux reference edges
  typedef logic [25:0] aux_ref_freq_t;
  typedef logic [15:0] device_id_t;

  // ----------------------------------------
  // register offsets from base
  // ----------------------------------------

  localparam logic [19:0] compat_num_reg      = 20'h00;
  localparam logic [19:0] scratch_reg         = 20'h0C;
  localparam logic [19:0] device_id_reg       = 20'h10;
  localparam logic [19:0] rfnoc_info_reg      = 20'h14;
  localparam logic [19:0] clock_ctrl_reg      = 20'h18;
  localparam logic [19:0] pps_ctrl_reg        = 20'h1C;
  localparam logic [19:0] chdr_clk_rate_reg   = 20'h20;
  localparam logic [19:0] num_timekeepers_reg = 20'h48;
  localparam logic [19:0] serial_num_low_reg  = 20'h4C;
  localparam logic [19:0] serial_num_high_reg = 20'h50;
  localparam logic [19:0] mfg_test_ctrl_reg   = 20'h54;
  localparam logic [19:0] mfg_test_status_reg = 20'h58;

  // ----------------------------------------
  // field positions, lsb of each field
  // ----------------------------------------

  localparam int compat_minor_pos       = 0;
  localparam int compat_major_pos       = 16;
  localparam int device_id_pos          = 0;
  localparam int pcie_present_bit       = 31;
  localparam int rfnoc_proto_minor_pos  = 0;
  localparam int rfnoc_proto_major_pos  = 8;
  localparam int chdr_width_pos         = 16;
  localparam int pps_select_pos         = 0;
  localparam int trig_io_select_pos     = 4;
  localparam int pll_sync_trigger_pos   = 8;
  localparam int pll_sync_done_pos      = 9;
  localparam int pll_sync_delay_pos     = 16;
  localparam int pps_brc_delay_pos      = 24;
  localparam int pps_prc_delay_pos      = 0;
  localparam int prc_rc_divider_pos     = 28;
  localparam int pps_rc_enabled_pos     = 31;
  localparam int mfg_en_gty_rcv_clk_pos = 0;
  localparam int mfg_en_fabric_clk_pos  = 1;
  localparam int aux_ref_freq_pos       = 0;

  // compatibility number
  localparam logic [15:0] fpga_version_major = 16'd7;
  localparam logic [15:0] fpga_version_minor = 16'd2;

  // zero is reserved for the device id
  localparam device_id_t default_device_id = 16'd1;

endpackage

// ==== rtl/aux_ref_freq_meter.sv ====
`timescale 1ns/1ps
/*
 * aux reference period meter
 * counts control-port clocks between rising edges, zero when saturated
 */
module aux_ref_freq_meter #(
  parameter int unsigned aux_ref_cnt_max = 48000000
) (
  input  logic                           s_ctrlport_clk,
  input  logic                           s_ctrlport_rst,
  input  logic                           fpga_aux_ref,
  output global_regs_pkg::aux_ref_freq_t aux_ref_freq
);
  import global_regs_pkg::*;

  // saturation point in counter width
  localparam aux_ref_freq_t cnt_max = aux_ref_freq_t'(aux_ref_cnt_max);

  logic [1:0]    aux_ref_sync;
  logic          aux_ref_q;
  logic          aux_ref_rise;
  aux_ref_freq_t aux_ref_cnt;

  // 2-flop synchronizer, delayed copy and registered rise pulse
  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      aux_ref_sync <= '0;
      aux_ref_q    <= 1'b0;
      aux_ref_rise <= 1'b0;
    end else begin
      aux_ref_sync <= {aux_ref_sync[0], fpga_aux_ref};
      aux_ref_q    <= aux_ref_sync[1];
      aux_ref_rise <= aux_ref_sync[1] && !aux_ref_q;
    end
  end

  // ----------------------------------------
  // period counter
  // ----------------------------------------

  // two rises P cycles apart latch P-1
  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      aux_ref_cnt  <= '0;
      aux_ref_freq <= '0;
    end else if (aux_ref_rise) begin
      // a saturated count reports zero
      aux_ref_freq <= (aux_ref_cnt < cnt_max) ? aux_ref_cnt : '0;
      aux_ref_cnt  <= '0;
    end else if (aux_ref_cnt < cnt_max) begin
      aux_ref_cnt <= aux_ref_cnt + 1'b1;
    end
  end

endmodule

// ==== rtl/global_regs_ctrlport.sv ====
`timescale 1ns/1ps
/*
 * global register file on the control port
 * decodes writes into the control registers, answers reads one cycle later
 */
module global_regs_ctrlport #(
  parameter int unsigned reg_base        = 0,
  parameter int unsigned reg_size        = 'hC00,
  parameter int unsigned chdr_clk_rate   = 200000000,
  parameter int unsigned chdr_w          = 64,
  parameter logic [15:0] rfnoc_protover  = 16'h0100,
  parameter int unsigned num_timekeepers = 1,
  parameter bit          pcie_present    = 1'b0
) (
  input  logic                            s_ctrlport_clk,
  input  logic                            s_ctrlport_rst,
  input  global_regs_pkg::ctrlport_req_t  req,
  output global_regs_pkg::ctrlport_resp_t resp,
  input  logic                            pll_sync_done,
  input  global_regs_pkg::aux_ref_freq_t  aux_ref_freq,
  output global_regs_pkg::clock_ctrl_t    clock_ctrl,
  output global_regs_pkg::pps_ctrl_t      pps_ctrl,
  output global_regs_pkg::mfg_test_ctrl_t mfg_test_ctrl,
  output global_regs_pkg::device_id_t     device_id
);
  import global_regs_pkg::*;

  // window bounds, one bit wider so base plus size cannot wrap
  localparam logic [32:0] window_lo = 33'(reg_base);
  localparam logic [32:0] window_hi = 33'(reg_base) + 33'(reg_size);

  logic         in_window;
  logic [19:0]  addr_offset;
  logic         wr_hit;
  logic         rd_hit;
  logic [31:0]  rd_word;
  logic [31:0]  scratch;
  logic [63:0]  serial_num;
  logic         resp_ack;
  ctrl_status_e resp_status;
  logic [31:0]  resp_data;

  // ----------------------------------------
  // address decode
  // ----------------------------------------

  assign in_window   = (33'(req.addr) >= window_lo) && (33'(req.addr) < window_hi);
  assign addr_offset = req.addr - window_lo[19:0];

  // writable offsets
  always_comb begin
    case (addr_offset)
      scratch_reg,
      device_id_reg,
      clock_ctrl_reg,
      pps_ctrl_reg,
      serial_num_low_reg,
      serial_num_high_reg,
      mfg_test_ctrl_reg: wr_hit = 1'b1;
      default:           wr_hit = 1'b0;
    endcase
  end

  // ----------------------------------------
  // writable registers
  // ----------------------------------------

  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      scratch       <= '0;
      serial_num    <= '0;
      device_id     <= default_device_id;
      clock_ctrl    <= '{pps_select:       pps_int_25mhz,
                         trig_io_select:   trig_io_input,
                         pll_sync_delay:   8'd0,
                         pll_sync_trigger: 1'b0,
                         pps_brc_delay:    8'd0};
      pps_ctrl      <= '0;
      mfg_test_ctrl <= '0;
    end else if (req.wr && in_window) begin
      case (addr_offset)
        scratch_reg: begin
          scratch <= req.data;
        end
        device_id_reg: begin
          device_id <= req.data[device_id_pos +: $bits(device_id_t)];
        end
        clock_ctrl_reg: begin
          clock_ctrl.pps_select <=
            pps_select_e'(req.data[pps_select_pos +: $bits(pps_select_e)]);
          clock_ctrl.trig_io_select <=
            trig_io_select_e'(req.data[trig_io_select_pos +: $bits(trig_io_select_e)]);
          clock_ctrl.pll_sync_delay   <= req.data[pll_sync_delay_pos +: 8];
          clock_ctrl.pll_sync_trigger <= req.data[pll_sync_trigger_pos];
          clock_ctrl.pps_brc_delay    <= req.data[pps_brc_delay_pos +: 8];
        end
        pps_ctrl_reg: begin
          pps_ctrl.pps_prc_delay  <= req.data[pps_prc_delay_pos +: 26];
          pps_ctrl.prc_rc_divider <= req.data[prc_rc_divider_pos +: 2];
          pps_ctrl.pps_rc_enabled <= req.data[pps_rc_enabled_pos];
        end
        // serial number in two halves
        serial_num_low_reg: begin
          serial_num[31:0] <= req.data;
        end
        serial_num_high_reg: begin
          serial_num[63:32] <= req.data;
        end
        mfg_test_ctrl_reg: begin
          mfg_test_ctrl.en_gty_rcv_clk <= req.data[mfg_en_gty_rcv_clk_pos];
          mfg_test_ctrl.en_fabric_clk  <= req.data[mfg_en_fabric_clk_pos];
        end
        default: begin
          // read-only or unmapped, nothing stored
        end
      endcase
    end
  end

  // ----------------------------------------
  // read word
  // ----------------------------------------

  // undefined bits stay zero
  always_comb begin
    rd_hit  = 1'b1;
    rd_word = '0;
    case (addr_offset)
      compat_num_reg: begin
        rd_word[compat_major_pos +: 16] = fpga_version_major;
        rd_word[compat_minor_pos +: 16] = fpga_version_minor;
      end
      scratch_reg: begin
        rd_word = scratch;
      end
      device_id_reg: begin
        rd_word[pcie_present_bit]                    = pcie_present;
        rd_word[device_id_pos +: $bits(device_id_t)] = device_id;
      end
      rfnoc_info_reg: begin
        rd_word[chdr_width_pos +: 16]       = 16'(chdr_w);
        rd_word[rfnoc_proto_major_pos +: 8] = rfnoc_protover[15:8];
        rd_word[rfnoc_proto_minor_pos +: 8] = rfnoc_protover[7:0];
      end
      clock_ctrl_reg: begin
        // sync trigger is not readable, sync done is the live level
        rd_word[pps_select_pos +: $bits(pps_select_e)]         = clock_ctrl.pps_select;
        rd_word[trig_io_select_pos +: $bits(trig_io_select_e)] = clock_ctrl.trig_io_select;
        rd_word[pll_sync_done_pos]                             = pll_sync_done;
        rd_word[pll_sync_delay_pos +: 8]                       = clock_ctrl.pll_sync_delay;
        rd_word[pps_brc_delay_pos +: 8]                        = clock_ctrl.pps_brc_delay;
      end
      pps_ctrl_reg: begin
        rd_word[pps_prc_delay_pos +: 26] = pps_ctrl.pps_prc_delay;
        rd_word[prc_rc_divider_pos +: 2] = pps_ctrl.prc_rc_divider;
        rd_word[pps_rc_enabled_pos]      = pps_ctrl.pps_rc_enabled;
      end
      chdr_clk_rate_reg: begin
        rd_word = 32'(chdr_clk_rate);
      end
      num_timekeepers_reg: begin
        rd_word = 32'(num_timekeepers);
      end
      serial_num_low_reg: begin
        rd_word = serial_num[31:0];
      end
      serial_num_high_reg: begin
        rd_word = serial_num[63:32];
      end
      mfg_test_ctrl_reg: begin
        rd_word[mfg_en_gty_rcv_clk_pos] = mfg_test_ctrl.en_gty_rcv_clk;
        rd_word[mfg_en_fabric_clk_pos]  = mfg_test_ctrl.en_fabric_clk;
      end
      mfg_test_status_reg: begin
        rd_word[aux_ref_freq_pos +: $bits(aux_ref_freq_t)] = aux_ref_freq;
      end
      default: begin
        rd_hit = 1'b0;
      end
    endcase
  end

  // ----------------------------------------
  // registered response
  // ----------------------------------------

  // no ack outside the window
  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      resp_ack <= 1'b0;
    end else begin
      resp_ack <= (req.wr || req.rd) && in_window;
    end
  end

  // write wins over read, write data is always zero
  always_ff @(posedge s_ctrlport_clk) begin
    if (req.wr) begin
      resp_status <= wr_hit ? sts_okay : sts_cmderr;
      resp_data   <= '0;
    end else begin
      resp_status <= rd_hit ? sts_okay : sts_cmderr;
      resp_data   <= rd_word;
    end
  end

  assign resp = '{ack: resp_ack, status: resp_status, data: resp_data};

endmodule

// ==== rtl/global_regs.sv ====
`timescale 1ns/1ps
/*
 * motherboard global registers
 * control-port register file plus aux reference period meter
 */
module global_regs #(
  parameter int unsigned reg_base        = 0,
  parameter int unsigned reg_size        = 'hC00,
  parameter int unsigned chdr_clk_rate   = 200000000,
  parameter int unsigned chdr_w          = 64,
  parameter logic [15:0] rfnoc_protover  = 16'h0100,
  parameter int unsigned num_timekeepers = 1,
  parameter bit          pcie_present    = 1'b0,
  parameter int unsigned aux_ref_cnt_max = 48000000
) (
  input  logic                            s_ctrlport_clk,
  input  logic                            s_ctrlport_rst,
  input  global_regs_pkg::ctrlport_req_t  req,
  output global_regs_pkg::ctrlport_resp_t resp,
  input  logic                            pll_sync_done,
  input  logic                            fpga_aux_ref,
  output global_regs_pkg::clock_ctrl_t    clock_ctrl,
  output global_regs_pkg::pps_ctrl_t      pps_ctrl,
  output global_regs_pkg::mfg_test_ctrl_t mfg_test_ctrl,
  output global_regs_pkg::device_id_t     device_id
);
  import global_regs_pkg::*;

  // measured period, level between edges
  aux_ref_freq_t aux_ref_freq;

  global_regs_ctrlport #(
    .reg_base        (reg_base),
    .reg_size        (reg_size),
    .chdr_clk_rate   (chdr_clk_rate),
    .chdr_w          (chdr_w),
    .rfnoc_protover  (rfnoc_protover),
    .num_timekeepers (num_timekeepers),
    .pcie_present    (pcie_present)
  ) regs0 (
    .s_ctrlport_clk (s_ctrlport_clk),
    .s_ctrlport_rst (s_ctrlport_rst),
    .req            (req),
    .resp           (resp),
    .pll_sync_done  (pll_sync_done),
    .aux_ref_freq   (aux_ref_freq),
    .clock_ctrl     (clock_ctrl),
    .pps_ctrl       (pps_ctrl),
    .mfg_test_ctrl  (mfg_test_ctrl),
    .device_id      (device_id)
  );

  aux_ref_freq_meter #(
    .aux_ref_cnt_max (aux_ref_cnt_max)
  ) meter0 (
    .s_ctrlport_clk (s_ctrlport_clk),
    .s_ctrlport_rst (s_ctrlport_rst),
    .fpga_aux_ref   (fpga_aux_ref),
    .aux_ref_freq   (aux_ref_freq)
  );

endmodule

// ==== verification/global_regs_tb_model.svh ====
/*
 * register model for the global register testbench
 * shadow registers, expected responses and typed compare tasks
 */
`ifndef global_regs_tb_model_svh
`define global_regs_tb_model_svh

  // shadow copy of the writable registers
  logic [31:0]    sh_scratch;
  logic [63:0]    sh_serial;
  device_id_t     sh_device_id;
  clock_ctrl_t    sh_clock_ctrl;
  pps_ctrl_t      sh_pps_ctrl;
  mfg_test_ctrl_t sh_mfg;
  int             checks = 0;
  int             errors = 0;

  function automatic void reset_shadow();
    sh_scratch    = '0;
    sh_serial     = '0;
    sh_device_id  = 16'd1;
    sh_clock_ctrl = '0;
    sh_pps_ctrl   = '0;
    sh_mfg        = '0;
  endfunction

  // unsigned wrap covers both ends of the window
  function automatic bit in_window(logic [19:0] a);
    return (32'(a) - reg_base) < reg_size;
  endfunction

  function automatic bit is_writable(logic [19:0] off);
    foreach (writable_regs[i]) begin
      if (writable_regs[i] == off) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic void apply_write(ctrlport_req_t r);
    logic [19:0] off;
    off = r.addr - 20'(reg_base);
    if (!r.wr || !in_window(r.addr)) return;
    case (off)
      scratch_reg:         sh_scratch = r.data;
      device_id_reg:       sh_device_id = r.data[15:0];
      clock_ctrl_reg: begin
        sh_clock_ctrl.pps_select       = pps_select_e'(r.data[1:0]);
        sh_clock_ctrl.trig_io_select   = trig_io_select_e'(r.data[5:4]);
        sh_clock_ctrl.pll_sync_trigger = r.data[8];
        sh_clock_ctrl.pll_sync_delay   = r.data[23:16];
        sh_clock_ctrl.pps_brc_delay    = r.data[31:24];
      end
      pps_ctrl_reg: begin
        sh_pps_ctrl.pps_prc_delay  = r.data[25:0];
        sh_pps_ctrl.prc_rc_divider = r.data[29:28];
        sh_pps_ctrl.pps_rc_enabled = r.data[31];
      end
      serial_num_low_reg:  sh_serial[31:0] = r.data;
      serial_num_high_reg: sh_serial[63:32] = r.data;
      mfg_test_ctrl_reg: begin
        sh_mfg.en_gty_rcv_clk = r.data[0];
        sh_mfg.en_fabric_clk  = r.data[1];
      end
      default: ;
    endcase
  endfunction

  // ----------------------------------------
  // expected response for one request
  // ----------------------------------------
  function automatic ctrlport_resp_t expect_resp(ctrlport_req_t r);
    ctrlport_resp_t e;
    logic [19:0]    off;
    e   = '0;
    off = r.addr - 20'(reg_base);
    // idle or outside the window, no ack
    if (!(r.wr || r.rd) || !in_window(r.addr)) return e;
    e.ack = 1'b1;
    if (r.wr) begin
      if (!is_writable(off)) e.status = sts_cmderr;
      return e;
    end
    case (off)
      compat_num_reg:      e.data = {fpga_version_major, fpga_version_minor};
      scratch_reg:         e.data = sh_scratch;
      device_id_reg:       e.data = {pcie_present, 15'd0, sh_device_id};
      rfnoc_info_reg:      e.data = {16'(chdr_w), rfnoc_protover};
      // trigger reads back as zero, bit 9 is the live sync done
      clock_ctrl_reg:      e.data = {sh_clock_ctrl.pps_brc_delay, sh_clock_ctrl.pll_sync_delay,
                                     6'd0, pll_sync_done, 1'b0, 2'd0,
                                     sh_clock_ctrl.trig_io_select, 2'd0,
                                     sh_clock_ctrl.pps_select};
      pps_ctrl_reg:        e.data = {sh_pps_ctrl.pps_rc_enabled, 1'b0,
                                     sh_pps_ctrl.prc_rc_divider, 2'd0,
                                     sh_pps_ctrl.pps_prc_delay};
      chdr_clk_rate_reg:   e.data = chdr_clk_rate;
      num_timekeepers_reg: e.data = num_timekeepers;
      serial_num_low_reg:  e.data = sh_serial[31:0];
      serial_num_high_reg: e.data = sh_serial[63:32];
      mfg_test_ctrl_reg:   e.data = {30'd0, sh_mfg.en_fabric_clk, sh_mfg.en_gty_rcv_clk};
      mfg_test_status_reg: e.data = {6'd0, exp_aux_freq};
      default:             e.status = sts_cmderr;
    endcase
    return e;
  endfunction

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  // status and data only matter when an ack is expected
  task automatic cmp_resp(string name, ctrlport_resp_t exp, ctrlport_resp_t act);
    checks++;
    if (act.ack !== exp.ack || (exp.ack && act !== exp)) begin
      errors++;
      $display("mismatch %s resp expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_clock_ctrl(string name, clock_ctrl_t exp, clock_ctrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s clock_ctrl expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_pps_ctrl(string name, pps_ctrl_t exp, pps_ctrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s pps_ctrl expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_mfg_test_ctrl(string name, mfg_test_ctrl_t exp, mfg_test_ctrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s mfg_test_ctrl expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_device_id(string name, device_id_t exp, device_id_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s device_id expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_aux_freq(string name, aux_ref_freq_t exp, aux_ref_freq_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s aux_ref_freq expected %0d actual %0d", name, exp, act);
    end
  endtask

`endif

// ==== verification/global_regs_tb.sv ====
`timescale 1ns/1ps
/*
 * testbench for the global register block
 * register traffic against a shadow model and the aux reference meter
 */
module global_regs_tb;
  import global_regs_pkg::*;

  localparam int unsigned reg_base        = 0;
  localparam int unsigned reg_size        = 'hC00;
  localparam int unsigned chdr_clk_rate   = 200000000;
  localparam int unsigned chdr_w          = 64;
  localparam logic [15:0] rfnoc_protover  = 16'h0100;
  localparam int unsigned num_timekeepers = 1;
  localparam bit          pcie_present    = 1'b1;
  localparam int unsigned aux_ref_cnt_max = 1000;

  localparam int clk_period = 40;
  localparam int n_rand     = 24;
  // summed test lengths in cycles
  localparam int len_total  = 5 + 20 + (2 * n_rand + 20) + 20 + 10
                              + 3 * (int'(aux_ref_cnt_max) + 120);
  localparam int len_limit  = len_total + 100;

  localparam logic [19:0] writable_regs [7] = '{
    scratch_reg, device_id_reg, clock_ctrl_reg, pps_ctrl_reg,
    serial_num_low_reg, serial_num_high_reg, mfg_test_ctrl_reg};
  localparam logic [19:0] const_regs [4] = '{
    compat_num_reg, rfnoc_info_reg, chdr_clk_rate_reg, num_timekeepers_reg};
  localparam logic [19:0] readable_regs [12] = '{
    compat_num_reg, scratch_reg, device_id_reg, rfnoc_info_reg,
    clock_ctrl_reg, pps_ctrl_reg, chdr_clk_rate_reg, num_timekeepers_reg,
    serial_num_low_reg, serial_num_high_reg, mfg_test_ctrl_reg, mfg_test_status_reg};

  logic           s_ctrlport_clk = 1'b0;
  logic           s_ctrlport_rst;
  ctrlport_req_t  req;
  ctrlport_resp_t resp;
  logic           pll_sync_done;
  logic           fpga_aux_ref;
  clock_ctrl_t    clock_ctrl;
  pps_ctrl_t      pps_ctrl;
  mfg_test_ctrl_t mfg_test_ctrl;
  device_id_t     device_id;

  // expected response one cycle behind its request
  ctrlport_resp_t exp_q;
  logic           exp_valid    = 1'b0;
  string          name_q;
  string          test_name    = "reset defaults";
  aux_ref_freq_t  exp_aux_freq = '0;

  `include "global_regs_tb_model.svh"

  global_regs #(
    .reg_base        (reg_base),
    .reg_size        (reg_size),
    .chdr_clk_rate   (chdr_clk_rate),
    .chdr_w          (chdr_w),
    .rfnoc_protover  (rfnoc_protover),
    .num_timekeepers (num_timekeepers),
    .pcie_present    (pcie_present),
    .aux_ref_cnt_max (aux_ref_cnt_max)
  ) dut0 (
    .s_ctrlport_clk (s_ctrlport_clk),
    .s_ctrlport_rst (s_ctrlport_rst),
    .req            (req),
    .resp           (resp),
    .pll_sync_done  (pll_sync_done),
    .fpga_aux_ref   (fpga_aux_ref),
    .clock_ctrl     (clock_ctrl),
    .pps_ctrl       (pps_ctrl),
    .mfg_test_ctrl  (mfg_test_ctrl),
    .device_id      (device_id)
  );

  always #(clk_period / 2) s_ctrlport_clk = ~s_ctrlport_clk;

  // ----------------------------------------
  // model and compare
  // ----------------------------------------
  // model takes each request at the same edge as the DUT
  always @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      reset_shadow();
      exp_valid <= 1'b0;
    end else begin
      exp_q     <= expect_resp(req);
      exp_valid <= 1'b1;
      name_q    <= test_name;
      apply_write(req);
    end
  end

  // response and output ports sampled mid-cycle
  always @(negedge s_ctrlport_clk) begin
    if (exp_valid) begin
      cmp_resp(name_q, exp_q, resp);
      cmp_clock_ctrl(name_q, sh_clock_ctrl, clock_ctrl);
      cmp_pps_ctrl(name_q, sh_pps_ctrl, pps_ctrl);
      cmp_mfg_test_ctrl(name_q, sh_mfg, mfg_test_ctrl);
      cmp_device_id(name_q, sh_device_id, device_id);
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  // one-cycle strobe from falling edge to falling edge
  task automatic send_request(logic wr, logic rd, logic [19:0] addr, logic [31:0] data);
    req = '{wr: wr, rd: rd, addr: addr, data: data};
    @(negedge s_ctrlport_clk);
    req.wr = 1'b0;
    req.rd = 1'b0;
  endtask

  task automatic write_reg(logic [19:0] addr, logic [31:0] data);
    send_request(1'b1, 1'b0, addr, data);
  endtask

  task automatic read_reg(logic [19:0] addr);
    send_request(1'b0, 1'b1, addr, 32'd0);
  endtask

  // rising edge now and the next one p cycles later
  task automatic aux_period(int p);
    fpga_aux_ref = 1'b1;
    repeat (p / 2) @(negedge s_ctrlport_clk);
    fpga_aux_ref = 1'b0;
    repeat (p - p / 2) @(negedge s_ctrlport_clk);
  endtask

  // two edges p apart and a read of the latched period
  task automatic measure(int p, aux_ref_freq_t exp);
    aux_period(p);
    fpga_aux_ref = 1'b1;
    repeat (5) @(negedge s_ctrlport_clk);
    exp_aux_freq = exp;
    cmp_aux_freq(test_name, exp, dut0.aux_ref_freq);
    read_reg(mfg_test_status_reg);
    fpga_aux_ref = 1'b0;
    repeat (4) @(negedge s_ctrlport_clk);
  endtask

  initial begin
    int idx;
    int p;
    void'($urandom(43731));
    s_ctrlport_rst = 1'b1;
    req            = '0;
    pll_sync_done  = 1'b0;
    fpga_aux_ref   = 1'b0;
    repeat (5) @(negedge s_ctrlport_clk);
    s_ctrlport_rst = 1'b0;

    test_name = "reset defaults";
    cmp_clock_ctrl(test_name, '0, clock_ctrl);
    cmp_pps_ctrl(test_name, '0, pps_ctrl);
    cmp_mfg_test_ctrl(test_name, '0, mfg_test_ctrl);
    cmp_device_id(test_name, 16'd1, device_id);
    cmp_aux_freq(test_name, '0, dut0.aux_ref_freq);
    foreach (readable_regs[i]) begin
      read_reg(readable_regs[i]);
    end

    test_name = "write and read back";
    repeat (n_rand) begin
      idx = int'($urandom % 7);
      write_reg(writable_regs[idx], $urandom);
      read_reg(writable_regs[idx]);
    end
    foreach (readable_regs[i]) begin
      read_reg(readable_regs[i]);
    end
    // write strobe wins over a read in the same cycle
    write_reg(scratch_reg, 32'h5a5a_a5a5);
    send_request(1'b1, 1'b1, scratch_reg, $urandom);
    read_reg(scratch_reg);
    pll_sync_done = 1'b1;
    read_reg(clock_ctrl_reg);
    pll_sync_done = 1'b0;
    read_reg(clock_ctrl_reg);

    test_name = "read-only constants";
    foreach (const_regs[i]) begin
      read_reg(const_regs[i]);
      write_reg(const_regs[i], $urandom);
      read_reg(const_regs[i]);
    end

    test_name = "address errors";
    read_reg(20'h004);
    read_reg(20'h060);
    write_reg(20'h008, $urandom);
    read_reg(20'hBFC);
    read_reg(20'hC00);
    write_reg(20'hC0C, $urandom);
    read_reg(20'hFFFFC);
    read_reg(scratch_reg);

    test_name = "reference measurement";
    measure(200, 26'd199);
    p = 20 + int'($urandom % 900);
    measure(p, aux_ref_freq_t'(p - 1));
    // gap past the limit saturates
    measure(int'(aux_ref_cnt_max) + 100, '0);

    repeat (3) @(negedge s_ctrlport_clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(len_limit * clk_period);
    $display("timeout, tests still running after %0d cycles", len_limit);
    $display("checks %0d, errors %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== global_regs.f ====
+incdir+verification
rtl/global_regs_pkg.sv
rtl/aux_ref_freq_meter.sv
rtl/global_regs_ctrlport.sv
rtl/global_regs.sv
verification/global_regs_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the global register testbench with Verilator, run it, look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module global_regs_tb \
  -f global_regs.f -o global_regs_sim &&
./obj_dir/global_regs_sim | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
